/* hdl/rename_pkg.sv */
// Sizes and index types for the rename back end
// Sizes must stay powers of two, since pointers wrap by overflow
`default_nettype none

package rename_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    // Architectural register count, RISC-V integer file
    localparam int NUM_ARCH_REGS = 32;

    // Physical register count, shared by map, free list and register file
    localparam int NUM_PHYS_REGS = 64;

    // In-flight instructions
    localparam int GL_DEPTH = 16;

    localparam int DATA_WIDTH = 64;

    //////////////////////////////////////////////////
    // Index and data types
    //////////////////////////////////////////////////

    // Architectural register index
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] reg_t;

    // Physical register index
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phreg_t;

    // Graduation list slot
    typedef logic [$clog2(GL_DEPTH)-1:0] gl_index_t;

    typedef logic [DATA_WIDTH-1:0] bus64_t;

    // One bit wider than phreg_t so a full list can be counted
    typedef logic [$clog2(NUM_PHYS_REGS):0] fl_count_t;

endpackage

`default_nettype wire

/* hdl/rename_ifc.sv */
// Writeback and retire buses used inside rename_core
// Writeback has no handshake; fire marks exactly one retiring cycle
`timescale 1ns/100ps
`default_nettype none

// One result per cycle with valid high
interface wb_if;
    logic                  valid;
    rename_pkg::phreg_t    prd;
    rename_pkg::gl_index_t gl_index;
    rename_pkg::bus64_t    data;

    modport source (output valid, prd, gl_index, data);
    modport sink   (input  valid, prd, gl_index, data);
endinterface

// Head of the graduation list as it retires
interface retire_if;
    logic               fire;
    logic               regfile_we;
    rename_pkg::reg_t   rd;
    rename_pkg::phreg_t prd;
    rename_pkg::phreg_t old_prd;

    modport source (output fire, regfile_we, rd, prd, old_prd);
    modport sink   (input  fire, regfile_we, rd, prd, old_prd);
endinterface

`default_nettype wire

/* hdl/free_list.sv */
// Free physical registers as a circular FIFO, 32..63 after reset
// Caller must not allocate while empty_o is high
`timescale 1ns/100ps
`default_nettype none

module free_list (
    input  wire logic               clk_i,
    input  wire logic               rstn_i,
    input  wire logic               alloc_i,
    retire_if.sink                  retire,
    output rename_pkg::phreg_t      head_o,
    output logic                    empty_o
);

    rename_pkg::phreg_t    fifo_q [rename_pkg::NUM_PHYS_REGS];
    rename_pkg::phreg_t    head_q;
    rename_pkg::phreg_t    tail_q;
    rename_pkg::fl_count_t count_q;
    logic                  push;

    // Old mapping of a retiring writer goes back to the pool
    assign push = retire.fire && retire.regfile_we;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Slot i starts as register 32 + i; slots past 31 wrap and are never popped first
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
                fifo_q[i] <= rename_pkg::phreg_t'(i + rename_pkg::NUM_ARCH_REGS);
            end
        end else if (push) begin
            fifo_q[tail_q] <= retire.old_prd;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= rename_pkg::phreg_t'(rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_ARCH_REGS);
            count_q <= rename_pkg::fl_count_t'(
                           rename_pkg::NUM_PHYS_REGS - rename_pkg::NUM_ARCH_REGS);
        end else begin
            if (alloc_i) begin
                head_q <= head_q + rename_pkg::phreg_t'(1);
            end
            if (push) begin
                tail_q <= tail_q + rename_pkg::phreg_t'(1);
            end
            // Simultaneous push and pop leave the count alone
            case ({push, alloc_i})
                2'b10:   count_q <= count_q + rename_pkg::fl_count_t'(1);
                2'b01:   count_q <= count_q - rename_pkg::fl_count_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o  = fifo_q[head_q];
    assign empty_o = (count_q == '0);

    // Rename must stall on an empty list
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i) alloc_i |-> !empty_o
    );

    // More frees than registers would mean a double release
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        push |-> (count_q != rename_pkg::fl_count_t'(rename_pkg::NUM_PHYS_REGS))
    );

endmodule

`default_nettype wire

/* hdl/rename_table.sv */
// Architectural to physical map plus per-register ready bits
// x0 is pinned to physical 0 and always ready
`timescale 1ns/100ps
`default_nettype none

module rename_table (
    input  wire logic               clk_i,
    input  wire logic               rstn_i,
    input  wire rename_pkg::reg_t   rs1_i,
    input  wire rename_pkg::reg_t   rs2_i,
    input  wire rename_pkg::reg_t   rd_i,
    input  wire logic               write_dst_i,
    input  wire rename_pkg::phreg_t new_dst_i,
    wb_if.sink                      wb,
    output rename_pkg::phreg_t      prs1_o,
    output rename_pkg::phreg_t      prs2_o,
    output rename_pkg::phreg_t      old_dst_o,
    output logic                    rdy1_o,
    output logic                    rdy2_o
);

    rename_pkg::phreg_t                 map_q [rename_pkg::NUM_ARCH_REGS];
    logic [rename_pkg::NUM_PHYS_REGS-1:0] ready_q;

    //////////////////////////////////////////////////
    // Map and ready state
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Identity map, every committed value present
            for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phreg_t'(i);
            end
            ready_q <= '1;
        end else begin
            if (wb.valid) begin
                ready_q[wb.prd] <= 1'b1;
            end
            // A fresh destination waits for its writeback
            if (write_dst_i) begin
                map_q[rd_i]        <= new_dst_i;
                ready_q[new_dst_i] <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Lookup with writeback snoop
    //////////////////////////////////////////////////

    always_comb begin
        prs1_o    = (rs1_i == '0) ? '0 : map_q[rs1_i];
        prs2_o    = (rs2_i == '0) ? '0 : map_q[rs2_i];
        old_dst_o = map_q[rd_i];

        // Same-cycle writeback counts as ready
        rdy1_o = (rs1_i == '0) || ready_q[prs1_o] || (wb.valid && (wb.prd == prs1_o));
        rdy2_o = (rs2_i == '0) || ready_q[prs2_o] || (wb.valid && (wb.prd == prs2_o));
    end

endmodule

`default_nettype wire

/* hdl/graduation_list.sv */
// In-order list of renamed instructions, retired from the head
// Caller must not push while full_o is high; entries become done by writeback only
`timescale 1ns/100ps
`default_nettype none

module graduation_list (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  push_i,
    input  wire rename_pkg::reg_t      rd_i,
    input  wire logic                  we_i,
    input  wire rename_pkg::phreg_t    prd_i,
    input  wire rename_pkg::phreg_t    old_prd_i,
    wb_if.sink                         wb,
    input  wire logic                  commit_ready_i,
    output logic                       full_o,
    output rename_pkg::gl_index_t      tail_o,
    output logic                       commit_valid_o,
    retire_if.source                   retire
);

    // Entry state
    logic [rename_pkg::GL_DEPTH-1:0] valid_q;
    logic [rename_pkg::GL_DEPTH-1:0] done_q;
    rename_pkg::gl_index_t           head_q;
    rename_pkg::gl_index_t           tail_q;

    // Entry payload
    rename_pkg::reg_t   rd_q      [rename_pkg::GL_DEPTH];
    logic               we_q      [rename_pkg::GL_DEPTH];
    rename_pkg::phreg_t prd_q     [rename_pkg::GL_DEPTH];
    rename_pkg::phreg_t old_prd_q [rename_pkg::GL_DEPTH];

    //////////////////////////////////////////////////
    // Pointers, valid and done
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (wb.valid) begin
                done_q[wb.gl_index] <= 1'b1;
            end
            if (push_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + rename_pkg::gl_index_t'(1);
            end
            if (retire.fire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + rename_pkg::gl_index_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            rd_q[tail_q]      <= rd_i;
            we_q[tail_q]      <= we_i;
            prd_q[tail_q]     <= prd_i;
            old_prd_q[tail_q] <= old_prd_i;
        end
    end

    //////////////////////////////////////////////////
    // Status and retirement
    //////////////////////////////////////////////////

    // In-order fill, so an occupied tail slot means every slot is taken
    assign full_o = valid_q[tail_q];
    assign tail_o = tail_q;

    assign commit_valid_o = valid_q[head_q] && done_q[head_q];

    assign retire.fire       = commit_valid_o && commit_ready_i;
    assign retire.regfile_we = we_q[head_q];
    assign retire.rd         = rd_q[head_q];
    assign retire.prd        = prd_q[head_q];
    assign retire.old_prd    = old_prd_q[head_q];

    // Each renamed instruction completes exactly once
    a_wb_live_entry: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wb.valid |-> (valid_q[wb.gl_index] && !done_q[wb.gl_index])
    );

endmodule

`default_nettype wire

/* hdl/phys_regfile.sv */
// Physical register storage, one write port and one commit read port
// Contents are undefined until written; register 0 is never written
`timescale 1ns/100ps
`default_nettype none

module phys_regfile (
    input  wire logic           clk_i,
    wb_if.sink                  wb,
    retire_if.sink              retire,
    output rename_pkg::bus64_t  commit_data_o
);

    rename_pkg::bus64_t regs_q [rename_pkg::NUM_PHYS_REGS];

    //////////////////////////////////////////////////
    // Writeback port
    //////////////////////////////////////////////////

    // Physical 0 backs x0 and stays zero
    always_ff @(posedge clk_i) begin
        if (wb.valid && (wb.prd != '0)) begin
            regs_q[wb.prd] <= wb.data;
        end
    end

    //////////////////////////////////////////////////
    // Commit read port
    //////////////////////////////////////////////////

    // Nothing is committed for instructions without a destination
    assign commit_data_o = retire.regfile_we ? regs_q[retire.prd] : '0;

endmodule

`default_nettype wire

/* hdl/rename_core.sv */
// Rename back end top with valid/ready rename, valid-only writeback and valid/ready commit
// One instruction renamed and at most one retired per cycle
`timescale 1ns/100ps
`default_nettype none

module rename_core (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    // Rename request
    input  wire logic                  ren_valid_i,
    input  wire rename_pkg::reg_t      ren_rs1_i,
    input  wire rename_pkg::reg_t      ren_rs2_i,
    input  wire rename_pkg::reg_t      ren_rd_i,
    input  wire logic                  ren_we_i,
    output logic                       ren_ready_o,
    // Rename result, same cycle
    output rename_pkg::phreg_t         ren_prs1_o,
    output logic                       ren_rdy1_o,
    output rename_pkg::phreg_t         ren_prs2_o,
    output logic                       ren_rdy2_o,
    output rename_pkg::phreg_t         ren_prd_o,
    output rename_pkg::phreg_t         ren_old_prd_o,
    output rename_pkg::gl_index_t      ren_gl_index_o,
    // Writeback
    input  wire logic                  wb_valid_i,
    input  wire rename_pkg::phreg_t    wb_prd_i,
    input  wire rename_pkg::gl_index_t wb_gl_index_i,
    input  wire rename_pkg::bus64_t    wb_data_i,
    // Commit
    input  wire logic                  commit_ready_i,
    output logic                       commit_valid_o,
    output rename_pkg::reg_t           commit_rd_o,
    output logic                       commit_we_o,
    output rename_pkg::phreg_t         commit_prd_o,
    output rename_pkg::bus64_t         commit_data_o
);

    wb_if     wb_bus ();
    retire_if retire_bus ();

    logic fl_empty;
    logic gl_full;
    logic dst_we;
    logic accept;
    logic alloc;

    assign wb_bus.valid    = wb_valid_i;
    assign wb_bus.prd      = wb_prd_i;
    assign wb_bus.gl_index = wb_gl_index_i;
    assign wb_bus.data     = wb_data_i;

    //////////////////////////////////////////////////
    // Rename handshake
    //////////////////////////////////////////////////

    assign ren_ready_o = !gl_full && !fl_empty;
    assign accept      = ren_valid_i && ren_ready_o;
    // Writes to x0 keep physical 0 and take nothing from the free list
    assign dst_we      = ren_we_i && (ren_rd_i != '0);
    assign alloc       = accept && dst_we;

    free_list free_list_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .alloc_i (alloc),
        .retire  (retire_bus.sink),
        .head_o  (ren_prd_o),
        .empty_o (fl_empty)
    );

    rename_table rename_table_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rs1_i       (ren_rs1_i),
        .rs2_i       (ren_rs2_i),
        .rd_i        (ren_rd_i),
        .write_dst_i (alloc),
        .new_dst_i   (ren_prd_o),
        .wb          (wb_bus.sink),
        .prs1_o      (ren_prs1_o),
        .prs2_o      (ren_prs2_o),
        .old_dst_o   (ren_old_prd_o),
        .rdy1_o      (ren_rdy1_o),
        .rdy2_o      (ren_rdy2_o)
    );

    graduation_list graduation_list_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .push_i         (accept),
        .rd_i           (ren_rd_i),
        .we_i           (dst_we),
        .prd_i          (ren_prd_o),
        .old_prd_i      (ren_old_prd_o),
        .wb             (wb_bus.sink),
        .commit_ready_i (commit_ready_i),
        .full_o         (gl_full),
        .tail_o         (ren_gl_index_o),
        .commit_valid_o (commit_valid_o),
        .retire         (retire_bus.source)
    );

    phys_regfile phys_regfile_inst (
        .clk_i         (clk_i),
        .wb            (wb_bus.sink),
        .retire        (retire_bus.sink),
        .commit_data_o (commit_data_o)
    );

    //////////////////////////////////////////////////
    // Commit outputs
    //////////////////////////////////////////////////

    assign commit_rd_o  = retire_bus.rd;
    assign commit_we_o  = retire_bus.regfile_we;
    assign commit_prd_o = retire_bus.prd;

endmodule

`default_nettype wire

/* tests/tb_rename_core.sv */
// Directed testbench for rename_core, checked against a model of map, free list and list order
// Writebacks of entries without a destination use physical 0, which the regfile never stores
`timescale 1ns/100ps
`default_nettype none

module tb_rename_core;

    localparam int          CLK_PERIOD      = 100;
    localparam int          WATCHDOG_CYCLES = 2000;
    localparam logic [31:0] LFSR_SEED       = 32'h8762_9960;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;

    // One graduation entry as the model sees it
    typedef struct packed {
        rename_pkg::reg_t      rd;
        logic                  we;
        rename_pkg::phreg_t    prd;
        rename_pkg::phreg_t    old_prd;
        rename_pkg::gl_index_t idx;
        logic                  done;
        rename_pkg::bus64_t    data;
    } gl_entry_t;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  ren_valid_i;
    rename_pkg::reg_t      ren_rs1_i;
    rename_pkg::reg_t      ren_rs2_i;
    rename_pkg::reg_t      ren_rd_i;
    logic                  ren_we_i;
    logic                  ren_ready_o;
    rename_pkg::phreg_t    ren_prs1_o;
    logic                  ren_rdy1_o;
    rename_pkg::phreg_t    ren_prs2_o;
    logic                  ren_rdy2_o;
    rename_pkg::phreg_t    ren_prd_o;
    rename_pkg::phreg_t    ren_old_prd_o;
    rename_pkg::gl_index_t ren_gl_index_o;
    logic                  wb_valid_i;
    rename_pkg::phreg_t    wb_prd_i;
    rename_pkg::gl_index_t wb_gl_index_i;
    rename_pkg::bus64_t    wb_data_i;
    logic                  commit_ready_i;
    logic                  commit_valid_o;
    rename_pkg::reg_t      commit_rd_o;
    logic                  commit_we_o;
    rename_pkg::phreg_t    commit_prd_o;
    rename_pkg::bus64_t    commit_data_o;

    // Reference model state
    rename_pkg::phreg_t                   model_map [rename_pkg::NUM_ARCH_REGS];
    logic [rename_pkg::NUM_PHYS_REGS-1:0] model_ready;
    rename_pkg::phreg_t                   model_fl [$];
    gl_entry_t                            model_gl [$];
    rename_pkg::gl_index_t                model_tail;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    rename_core dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_TAPS : 32'h0);
            r    = {r[62:0], b};
        end
        return r;
    endfunction

    task automatic check_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
            model_map[i] = rename_pkg::phreg_t'(i);
        end
        model_ready = '1;
        model_fl.delete();
        for (int i = rename_pkg::NUM_ARCH_REGS; i < rename_pkg::NUM_PHYS_REGS; i++) begin
            model_fl.push_back(rename_pkg::phreg_t'(i));
        end
        model_gl.delete();
        model_tail = '0;
    endtask

    function automatic logic ren_ready_expected();
        return (model_gl.size() < rename_pkg::GL_DEPTH) && (model_fl.size() > 0);
    endfunction

    // Stored ready bit or a writeback driven in the same cycle
    function automatic logic lookup_ready(input rename_pkg::reg_t rs, input rename_pkg::phreg_t p);
        return (rs == '0) || model_ready[p] || (wb_valid_i && (wb_prd_i == p));
    endfunction

    task automatic drive_rename(input rename_pkg::reg_t rs1, input rename_pkg::reg_t rs2,
                                input rename_pkg::reg_t rd, input logic we);
        ren_valid_i = 1'b1;
        ren_rs1_i   = rs1;
        ren_rs2_i   = rs2;
        ren_rd_i    = rd;
        ren_we_i    = we;
    endtask

    // Result for the entry at queue position pos
    task automatic drive_wb(input int pos);
        wb_valid_i    = 1'b1;
        wb_prd_i      = model_gl[pos].we ? model_gl[pos].prd : '0;
        wb_gl_index_i = model_gl[pos].idx;
        wb_data_i     = rand_bits(64);
    endtask

    task automatic check_rename();
        rename_pkg::phreg_t p1;
        rename_pkg::phreg_t p2;
        #1;
        p1 = (ren_rs1_i == '0) ? '0 : model_map[ren_rs1_i];
        p2 = (ren_rs2_i == '0) ? '0 : model_map[ren_rs2_i];
        check_hex("ren_ready_o", ren_ready_o, ren_ready_expected());
        if (ren_ready_expected()) begin
            check_hex("ren_prs1_o", ren_prs1_o, p1);
            check_hex("ren_rdy1_o", ren_rdy1_o, lookup_ready(ren_rs1_i, p1));
            check_hex("ren_prs2_o", ren_prs2_o, p2);
            check_hex("ren_rdy2_o", ren_rdy2_o, lookup_ready(ren_rs2_i, p2));
            check_hex("ren_prd_o", ren_prd_o, model_fl[0]);
            check_hex("ren_old_prd_o", ren_old_prd_o, model_map[ren_rd_i]);
            check_hex("ren_gl_index_o", ren_gl_index_o, model_tail);
        end
    endtask

    task automatic check_commit();
        logic exp_valid;
        #1;
        exp_valid = (model_gl.size() > 0) && model_gl[0].done;
        check_hex("commit_valid_o", commit_valid_o, exp_valid);
        if (exp_valid) begin
            check_hex("commit_rd_o", commit_rd_o, model_gl[0].rd);
            check_hex("commit_we_o", commit_we_o, model_gl[0].we);
            check_hex("commit_prd_o", commit_prd_o, model_gl[0].prd);
            check_hex("commit_data_o", commit_data_o, model_gl[0].we ? model_gl[0].data : '0);
        end
    endtask

    // Model follows what the edge does, then inputs go idle
    task automatic clock_edge();
        gl_entry_t e;
        logic      accept;
        logic      fire;
        accept = ren_valid_i && ren_ready_expected();
        fire   = commit_ready_i && (model_gl.size() > 0) && model_gl[0].done;
        if (wb_valid_i) begin
            model_ready[wb_prd_i] = 1'b1;
            foreach (model_gl[i]) begin
                if (model_gl[i].idx == wb_gl_index_i) begin
                    model_gl[i].done = 1'b1;
                    model_gl[i].data = wb_data_i;
                end
            end
        end
        if (accept) begin
            e.rd      = ren_rd_i;
            e.we      = ren_we_i && (ren_rd_i != '0);
            e.prd     = model_fl[0];
            e.old_prd = model_map[ren_rd_i];
            e.idx     = model_tail;
            e.done    = 1'b0;
            e.data    = '0;
            if (e.we) begin
                void'(model_fl.pop_front());
                model_map[ren_rd_i] = e.prd;
                model_ready[e.prd]  = 1'b0;
            end
            model_gl.push_back(e);
            model_tail++;
        end
        if (fire) begin
            if (model_gl[0].we) begin
                model_fl.push_back(model_gl[0].old_prd);
            end
            void'(model_gl.pop_front());
        end
        @(posedge clk_i);
        #10;
        ren_valid_i = 1'b0;
        wb_valid_i  = 1'b0;
    endtask

    task automatic wait_commit(input int max_cycles);
        int n;
        n = 0;
        while (!commit_valid_o && (n < max_cycles)) begin
            clock_edge();
            n++;
        end
        if (!commit_valid_o) begin
            errors++;
            $display("commit_valid_o did not rise for the head entry at %0t", $time);
        end
    endtask

    // Youngest first, so only the last one releases the head
    task automatic writeback_reverse();
        for (int i = model_gl.size() - 1; i >= 0; i--) begin
            if (!model_gl[i].done) begin
                drive_wb(i);
                check_commit();
                clock_edge();
            end
        end
    endtask

    task automatic drain_commits();
        commit_ready_i = 1'b1;
        for (int n = 0; (n < 4 * rename_pkg::GL_DEPTH) && (model_gl.size() > 0); n++) begin
            check_commit();
            clock_edge();
        end
        commit_ready_i = 1'b0;
        if (model_gl.size() > 0) begin
            errors++;
            $display("Graduation list did not drain at %0t", $time);
        end
    endtask

    task automatic rename_random();
        drive_rename(rename_pkg::reg_t'(rand_bits(5)), rename_pkg::reg_t'(rand_bits(5)),
                     rename_pkg::reg_t'(rand_bits(5)) | rename_pkg::reg_t'(1), 1'b1);
        check_rename();
        clock_edge();
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_state();
        check_hex("ren_ready_o", ren_ready_o, 1'b1);
        check_hex("commit_valid_o", commit_valid_o, 1'b0);
        drive_rename(5'd1, 5'd0, 5'd1, 1'b1);
        check_rename();
        check_hex("ren_prs1_o", ren_prs1_o, 64'd1);
        check_hex("ren_rdy1_o", ren_rdy1_o, 1'b1);
        check_hex("ren_prd_o", ren_prd_o, 64'd32);
        check_hex("ren_old_prd_o", ren_old_prd_o, 64'd1);
        clock_edge();
    endtask

    task automatic chained_renames();
        rename_pkg::reg_t   prev_rd;
        rename_pkg::reg_t   rd;
        rename_pkg::phreg_t head_prd;
        prev_rd = 5'd1;
        for (int i = 0; i < 6; i++) begin
            rd = rename_pkg::reg_t'(rand_bits(5)) | rename_pkg::reg_t'(1);
            drive_rename(rename_pkg::reg_t'(rand_bits(5)), prev_rd, rd, 1'b1);
            check_rename();
            // Producer not yet written back
            check_hex("ren_rdy2_o", ren_rdy2_o, 1'b0);
            clock_edge();
            prev_rd = rd;
        end
        head_prd = model_fl[0];
        drive_rename(5'd3, 5'd4, 5'd0, 1'b1);
        check_rename();
        clock_edge();
        drive_rename(5'd3, 5'd4, 5'd7, 1'b0);
        check_rename();
        clock_edge();
        // Neither rename took a register
        check_hex("ren_prd_o", ren_prd_o, head_prd);
    endtask

    task automatic writeback_readiness();
        drive_rename(5'd0, 5'd0, 5'd5, 1'b1);
        check_rename();
        clock_edge();
        drive_wb(model_gl.size() - 1);
        clock_edge();
        drive_rename(5'd5, 5'd0, 5'd0, 1'b0);
        check_rename();
        check_hex("ren_rdy1_o", ren_rdy1_o, 1'b1);
        clock_edge();
        drive_rename(5'd0, 5'd0, 5'd6, 1'b1);
        check_rename();
        clock_edge();
        // Lookup and writeback of the same register in one cycle
        drive_wb(model_gl.size() - 1);
        drive_rename(5'd6, 5'd0, 5'd0, 1'b0);
        check_rename();
        check_hex("ren_rdy1_o", ren_rdy1_o, 1'b1);
        clock_edge();
    endtask

    task automatic ordered_commit();
        commit_ready_i = 1'b0;
        writeback_reverse();
        wait_commit(4);
        // Head must hold while commit is stalled
        repeat (3) begin
            check_commit();
            clock_edge();
        end
        drain_commits();
    endtask

    task automatic recycle_and_stall();
        for (int i = 0; i < rename_pkg::GL_DEPTH; i++) begin
            rename_random();
        end
        check_hex("ren_ready_o", ren_ready_o, 1'b0);
        // A request while stalled is not taken
        drive_rename(5'd1, 5'd2, 5'd3, 1'b1);
        check_rename();
        clock_edge();
        writeback_reverse();
        drain_commits();
        // Enough allocations to reach the registers freed at commit
        repeat (4) begin
            for (int i = 0; i < 8; i++) begin
                rename_random();
            end
            writeback_reverse();
            drain_commits();
        end
    endtask

    initial begin
        errors         = 0;
        checks         = 0;
        lfsr           = LFSR_SEED;
        rstn_i         = 1'b0;
        ren_valid_i    = 1'b0;
        ren_rs1_i      = '0;
        ren_rs2_i      = '0;
        ren_rd_i       = '0;
        ren_we_i       = 1'b0;
        wb_valid_i     = 1'b0;
        wb_prd_i       = '0;
        wb_gl_index_i  = '0;
        wb_data_i      = '0;
        commit_ready_i = 1'b0;
        model_reset();
        repeat (2) @(posedge clk_i);
        #10;
        rstn_i = 1'b1;

        reset_state();
        chained_renames();
        writeback_readiness();
        ordered_commit();
        recycle_and_stall();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rename_core.f */
hdl/rename_pkg.sv
hdl/rename_ifc.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/graduation_list.sv
hdl/phys_regfile.sv
hdl/rename_core.sv
tests/tb_rename_core.sv

/* Makefile */
TOP := tb_rename_core

.PHONY: all run lint clean

all: run

obj_dir/sim: rename_core.f hdl/*.sv tests/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f rename_core.f \
		--Mdir obj_dir -o sim

run: obj_dir/sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f rename_core.f

clean:
	rm -rf obj_dir
